//--- design/t04Pkg.sv
package t04Pkg;

  // keypad scan timing
  // cycles each column stays driven
  localparam int SCAN_PERIOD = 4;
  // full scans that must agree before a key counts
  localparam int DEBOUNCE_SCANS = 2;

  // key code reported while nothing is held
  localparam logic [4:0] KEY_NONE = 5'd16;

  // lcd memory write command, sent ahead of every data byte
  localparam logic [7:0] CMD_MEM_WRITE = 8'h2C;

  // operation decoded from a key code
  typedef enum logic [2:0] {
    opDigit,
    opAdd,
    opSub,
    opClear,
    opXor,
    opBad
  } keyOpT;

  // debounce states of the keypad scanner
  typedef enum logic [1:0] {
    scanIdle,
    scanHeld,
    scanRelease
  } scanStateT;

  // lcd write sequence states
  typedef enum logic [2:0] {
    wIdle,
    wSetup,
    wStrobe,
    wHold,
    wDone
  } screenStateT;

endpackage

//--- design/keypadScanner.sv
`timescale 1ns/1ps

module keypadScanner
  import t04Pkg::*;
(
  input  logic       clk,
  input  logic       arstN,
  input  logic [3:0] row,
  output logic [3:0] column,
  output logic       keyValid,
  output logic [4:0] keyCode
);

  // column slot timing
  logic [$clog2(SCAN_PERIOD)-1:0] slotCnt;
  logic [1:0] colIdx;
  logic       sampleNow;
  logic       scanEnd;

  // rows seen in the current sample
  logic [2:0] rowOnes;
  logic [1:0] rowIdx;

  // per-scan hit collection, hitCnt saturates at 2
  logic [1:0] hitCnt;
  logic [1:0] hitNext;
  logic [3:0] candCode;
  logic [3:0] candNext;
  logic       scanSingle;
  logic       scanEmpty;

  // debounce
  scanStateT state;
  logic [3:0] heldCode;
  logic [$clog2(DEBOUNCE_SCANS+1)-1:0] agreeCnt;

  // sample in the last cycle of a driven slot
  assign sampleNow = (column != 4'b0000) && (int'(slotCnt) == SCAN_PERIOD - 1);
  // column 3 sample closes a full scan
  assign scanEnd = sampleNow && (colIdx == 2'd3);

  // one-hot column walk, starts one cycle after reset
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      column  <= 4'b0000;
      colIdx  <= 2'd0;
      slotCnt <= '0;
    end else if (column == 4'b0000) begin
      column <= 4'b0001;
    end else if (sampleNow) begin
      slotCnt <= '0;
      colIdx  <= colIdx + 2'd1;
      column  <= {column[2:0], column[3]};
    end else begin
      slotCnt <= slotCnt + 1'b1;
    end
  end

  // count active rows and note which one
  always_comb begin
    rowOnes = 3'd0;
    rowIdx  = 2'd0;
    for (int i = 0; i < 4; i++) begin
      if (row[i]) begin
        rowOnes = rowOnes + 3'd1;
        rowIdx  = 2'(i);
      end
    end
  end

  // fold this sample into the running scan result
  always_comb begin
    hitNext  = hitCnt;
    candNext = candCode;
    // first single hit of the scan becomes the candidate
    if (rowOnes == 3'd1 && hitCnt == 2'd0) begin
      candNext = {rowIdx, colIdx};
    end
    if (rowOnes >= 3'd2) begin
      hitNext = 2'd2;
    end else if (rowOnes == 3'd1) begin
      hitNext = (hitCnt == 2'd0) ? 2'd1 : 2'd2;
    end
  end

  assign scanSingle = (hitNext == 2'd1);
  assign scanEmpty  = (hitNext == 2'd0);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      hitCnt   <= 2'd0;
      candCode <= 4'd0;
    end else if (scanEnd) begin
      // fresh scan starts empty
      hitCnt <= 2'd0;
    end else if (sampleNow) begin
      hitCnt   <= hitNext;
      candCode <= candNext;
    end
  end

  // debounce fsm, acts once per full scan
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state    <= scanIdle;
      heldCode <= 4'd0;
      agreeCnt <= '0;
      keyValid <= 1'b0;
      keyCode  <= KEY_NONE;
    end else begin
      keyValid <= 1'b0;
      if (scanEnd) begin
        case (state)
          scanIdle: begin
            if (scanSingle) begin
              heldCode <= candNext;
              agreeCnt <= 1'b1;
              state    <= scanHeld;
            end else if (!scanEmpty) begin
              // two keys together, wait them out
              state <= scanRelease;
            end
          end
          scanHeld: begin
            if (scanEmpty) begin
              // bounced away before acceptance
              state <= scanIdle;
            end else if (!scanSingle) begin
              state <= scanRelease;
            end else if (candNext != heldCode) begin
              heldCode <= candNext;
              agreeCnt <= 1'b1;
            end else if (int'(agreeCnt) + 1 >= DEBOUNCE_SCANS) begin
              keyValid <= 1'b1;
              keyCode  <= {1'b0, heldCode};
              state    <= scanRelease;
            end else begin
              agreeCnt <= agreeCnt + 1'b1;
            end
          end
          scanRelease: begin
            // one clean scan rearms the scanner
            if (scanEmpty) begin
              keyCode <= KEY_NONE;
              state   <= scanIdle;
            end
          end
          default: state <= scanIdle;
        endcase
      end
    end
  end

  // at most one column driven at a time
  assert property (@(posedge clk) disable iff (!arstN) $onehot0(column));

  // single strobe per accepted press
  assert property (@(posedge clk) disable iff (!arstN) keyValid |=> !keyValid);

endmodule

//--- design/calcCore.sv
`timescale 1ns/1ps

module calcCore
  import t04Pkg::*;
(
  input  logic       clk,
  input  logic       arstN,
  input  logic       keyValid,
  input  logic [4:0] keyCode,
  input  logic       busy,
  output logic [7:0] acc,
  output logic [7:0] entry,
  output logic       carry,
  output logic       badKey,
  output logic       updateReq,
  output logic [7:0] updateData
);

  keyOpT keyOp;

  // arithmetic on the current registers
  logic [8:0] sum;
  logic [8:0] diff;
  logic [7:0] entryTen;

  // next register values
  logic [7:0] accNext;
  logic [7:0] entryNext;
  logic       carryNext;
  logic       badNext;

  // screen update bookkeeping
  logic accCmd;
  logic wantUpdate;
  logic pending;

  // key code to operation
  always_comb begin
    case (keyCode)
      5'd10:   keyOp = opAdd;
      5'd11:   keyOp = opSub;
      5'd12:   keyOp = opClear;
      5'd13:   keyOp = opXor;
      default: keyOp = (keyCode < 5'd10) ? opDigit : opBad;
    endcase
  end

  // 9 bits so bit 8 holds carry or borrow
  assign sum  = {1'b0, acc} + {1'b0, entry};
  assign diff = {1'b0, acc} - {1'b0, entry};
  // entry * 10 as 8x + 2x, wraps at 256
  assign entryTen = {entry[4:0], 3'b000} + {entry[6:0], 1'b0};

  always_comb begin
    accNext   = acc;
    entryNext = entry;
    carryNext = carry;
    badNext   = badKey;
    accCmd    = 1'b0;
    if (keyValid) begin
      case (keyOp)
        opDigit: begin
          entryNext = entryTen + {4'b0000, keyCode[3:0]};
        end
        opAdd: begin
          accNext   = sum[7:0];
          carryNext = sum[8];
          entryNext = 8'd0;
          accCmd    = 1'b1;
        end
        opSub: begin
          // borrow shows up in bit 8
          accNext   = diff[7:0];
          carryNext = diff[8];
          entryNext = 8'd0;
          accCmd    = 1'b1;
        end
        opXor: begin
          accNext   = acc ^ entry;
          carryNext = 1'b0;
          entryNext = 8'd0;
          accCmd    = 1'b1;
        end
        opClear: begin
          accNext   = 8'd0;
          entryNext = 8'd0;
          carryNext = 1'b0;
          badNext   = 1'b0;
          accCmd    = 1'b1;
        end
        opBad: begin
          badNext = 1'b1;
        end
        default: begin
          badNext = 1'b1;
        end
      endcase
    end
  end

  // new command or a deferred one both want the screen
  assign wantUpdate = accCmd || pending;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      acc        <= 8'd0;
      entry      <= 8'd0;
      carry      <= 1'b0;
      badKey     <= 1'b0;
      updateReq  <= 1'b0;
      updateData <= 8'd0;
      pending    <= 1'b0;
    end else begin
      acc       <= accNext;
      entry     <= entryNext;
      carry     <= carryNext;
      badKey    <= badNext;
      updateReq <= 1'b0;
      if (wantUpdate) begin
        // writer is free only with busy low and no request in flight
        if (!busy && !updateReq) begin
          updateReq  <= 1'b1;
          updateData <= accNext;
          pending    <= 1'b0;
        end else begin
          // only the latest acc gets sent later
          pending <= 1'b1;
        end
      end
    end
  end

  // request never lands on a busy writer
  assert property (@(posedge clk) disable iff (!arstN) updateReq |-> !busy);

endmodule

//--- design/screenWriter.sv
`timescale 1ns/1ps

module screenWriter
  import t04Pkg::*;
(
  input  logic       clk,
  input  logic       arstN,
  input  logic       updateReq,
  input  logic [7:0] updateData,
  output logic       busy,
  output logic       csx,
  output logic       dcx,
  output logic       wrx,
  output logic [7:0] data
);

  screenStateT state;
  // 0 while the command byte is out, 1 for the data byte
  logic       byteSel;
  // acc value latched at the request
  logic [7:0] dataReg;

  // sequence per update
  // setup, strobe, hold for the command byte
  // setup, strobe, hold for the data byte
  // done, then csx back high
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state   <= wIdle;
      byteSel <= 1'b0;
      dataReg <= 8'd0;
    end else begin
      case (state)
        wIdle: begin
          if (updateReq) begin
            dataReg <= updateData;
            byteSel <= 1'b0;
            state   <= wSetup;
          end
        end
        wSetup: begin
          // data and dcx settle with wrx still high
          state <= wStrobe;
        end
        wStrobe: begin
          state <= wHold;
        end
        wHold: begin
          // lcd latched on the wrx rise into this state
          if (!byteSel) begin
            byteSel <= 1'b1;
            state   <= wSetup;
          end else begin
            state <= wDone;
          end
        end
        wDone: begin
          byteSel <= 1'b0;
          state   <= wIdle;
        end
        default: state <= wIdle;
      endcase
    end
  end

  // pin decode from state
  assign busy = (state != wIdle);
  assign csx  = (state == wIdle);
  assign wrx  = (state != wStrobe);
  // dcx low means command
  assign dcx  = byteSel;
  assign data = byteSel ? dataReg : CMD_MEM_WRITE;

  // write strobe only inside a selected transfer
  assert property (@(posedge clk) disable iff (!arstN) !wrx |-> !csx);

  // chip select stays low for the full 7 cycle transfer
  assert property (@(posedge clk) disable iff (!arstN)
    $fell(csx) |-> !csx [*7] ##1 csx);

endmodule

//--- design/top.sv
`timescale 1ns/1ps

module top
  import t04Pkg::*;
(
  input  logic        hz100,
  input  logic        arstN,
  input  logic [20:0] pb,
  output logic [7:0]  left,
  output logic [7:0]  right,
  output logic [7:0]  ss7,
  output logic [7:0]  ss6,
  output logic [7:0]  ss5,
  output logic [7:0]  ss4,
  output logic [7:0]  ss3,
  output logic [7:0]  ss2,
  output logic [7:0]  ss1,
  output logic [7:0]  ss0,
  output logic        red,
  output logic        green,
  output logic        blue
);

  // keypad
  logic [3:0] row;
  logic [3:0] column;
  logic       keyValid;
  logic [4:0] keyCode;

  // calculator state
  logic [7:0] acc;
  logic [7:0] entry;
  logic       carry;
  logic       badKey;

  // screen path
  logic       updateReq;
  logic [7:0] updateData;
  logic       busy;
  logic       csx;
  logic       dcx;
  logic       wrx;
  logic [7:0] data;

  // keypad rows wired to push buttons, row 3 first
  assign row = {pb[15], pb[11], pb[7], pb[3]};

  keypadScanner keypadScanner0 (
    .clk(hz100),
    .arstN(arstN),
    .row(row),
    .column(column),
    .keyValid(keyValid),
    .keyCode(keyCode)
  );

  calcCore calcCore0 (
    .clk(hz100),
    .arstN(arstN),
    .keyValid(keyValid),
    .keyCode(keyCode),
    .busy(busy),
    .acc(acc),
    .entry(entry),
    .carry(carry),
    .badKey(badKey),
    .updateReq(updateReq),
    .updateData(updateData)
  );

  screenWriter screenWriter0 (
    .clk(hz100),
    .arstN(arstN),
    .updateReq(updateReq),
    .updateData(updateData),
    .busy(busy),
    .csx(csx),
    .dcx(dcx),
    .wrx(wrx),
    .data(data)
  );

  // raw status on the seven segment lines
  assign ss0 = {4'b0000, column};
  assign ss1 = {3'b000, keyCode};
  assign ss2 = 8'd0;
  assign ss3 = 8'd0;
  assign ss4 = 8'd0;
  assign ss5 = entry;
  assign ss6 = 8'd0;
  assign ss7 = acc;

  // lcd bus on the led rows
  assign right = {5'b00000, wrx, dcx, csx};
  assign left  = data;

  assign red   = busy;
  assign green = carry;
  assign blue  = badKey;

  // the core never sees a strobe without a real key
  assert property (@(posedge hz100) disable iff (!arstN)
    keyValid |-> keyCode != KEY_NONE);

endmodule

//--- tb/tbTop.sv
`timescale 1ns/1ps

module tbTop
  import t04Pkg::*;
();

  // one full keypad scan in clock cycles
  localparam int SCAN_CYCLES = 4 * SCAN_PERIOD;

  // expected calculator state plus whether an lcd write follows
  typedef struct packed {
    logic [7:0] acc;
    logic [7:0] entry;
    logic       carry;
    logic       bad;
    logic       write;
  } calcStateT;

  logic        hz100;
  logic        arstN;
  logic [20:0] pb = '0;
  logic [7:0]  left;
  logic [7:0]  right;
  logic [7:0]  ss7;
  logic [7:0]  ss6;
  logic [7:0]  ss5;
  logic [7:0]  ss4;
  logic [7:0]  ss3;
  logic [7:0]  ss2;
  logic [7:0]  ss1;
  logic [7:0]  ss0;
  logic        red;
  logic        green;
  logic        blue;

  // keys held by the keypad model
  logic [4:0] keyA;
  logic [4:0] keyB;
  calcStateT  model;

  // lcd bus capture
  logic       lcdDcx[$];
  logic [7:0] lcdData[$];
  int         lowCycles = 0;
  int         xferCnt = 0;

  top dut0 (
    .hz100(hz100), .arstN(arstN), .pb(pb), .left(left), .right(right),
    .ss7(ss7), .ss6(ss6), .ss5(ss5), .ss4(ss4),
    .ss3(ss3), .ss2(ss2), .ss1(ss1), .ss0(ss0),
    .red(red), .green(green), .blue(blue)
  );

  initial begin
    hz100 = 1'b0;
    forever #50 hz100 = ~hz100;
  end

  task automatic failRun();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic reportError(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    failRun();
  endtask

  task automatic timeoutStop(input string msg);
    $display("Timeout at time %0t: %s", $time, msg);
    failRun();
  endtask

  task automatic checkByte(input logic [7:0] got, input logic gotDcx,
                           input logic [7:0] exp, input logic expDcx);
    if (got !== exp || gotDcx !== expDcx)
      reportError($sformatf("lcd write %02h dcx %b, expected %02h dcx %b",
                            got, gotDcx, exp, expDcx));
  endtask

  task automatic checkReg(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp)
      reportError($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  task automatic checkFlags(input logic carry, input logic bad,
                            input logic expCarry, input logic expBad);
    if (carry !== expCarry || bad !== expBad)
      reportError($sformatf("carry %b badKey %b, expected %b %b",
                            carry, bad, expCarry, expBad));
  endtask

  task automatic checkKey(input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp)
      reportError($sformatf("key code %0d on ss1, expected %0d", got, exp));
  endtask

  // calculator rules applied to the model state
  function automatic calcStateT nextState(input calcStateT cur, input logic [4:0] code);
    keyOpT op;
    int    t;
    nextState = cur;
    nextState.write = 1'b0;
    if (code <= 5'd9) op = opDigit;
    else if (code == 5'd10) op = opAdd;
    else if (code == 5'd11) op = opSub;
    else if (code == 5'd12) op = opClear;
    else if (code == 5'd13) op = opXor;
    else op = opBad;
    case (op)
      opDigit: nextState.entry = 8'((int'(cur.entry) * 10 + int'(code)) % 256);
      opAdd: begin
        t = int'(cur.acc) + int'(cur.entry);
        nextState.acc = 8'(t % 256);
        nextState.carry = (t > 255);
      end
      opSub: begin
        t = int'(cur.acc) - int'(cur.entry);
        nextState.acc = 8'((t + 256) % 256);
        nextState.carry = (t < 0);
      end
      opXor: begin
        nextState.acc = cur.acc ^ cur.entry;
        nextState.carry = 1'b0;
      end
      opClear: nextState = '0;
      default: nextState.bad = 1'b1;
    endcase
    // every accumulator command clears entry and writes the screen
    if (op inside {opAdd, opSub, opXor, opClear}) begin
      nextState.entry = 8'd0;
      nextState.write = 1'b1;
    end
  endfunction

  // pb row line for a key while its column is driven
  function automatic logic [20:0] keyLines(input logic [3:0] cols, input logic [4:0] code);
    keyLines = '0;
    if (code != KEY_NONE && cols[code[1:0]])
      keyLines[3 + 4 * code[3:2]] = 1'b1;
  endfunction

  // keypad model follows the scanned column
  always @(negedge hz100) begin
    pb = keyLines(ss0[3:0], keyA) | keyLines(ss0[3:0], keyB);
  end

  // lcd latches on wrx rising
  always @(posedge right[2]) begin
    if (arstN === 1'b1) begin
      lcdDcx.push_back(right[1]);
      lcdData.push_back(left);
    end
  end

  // csx low time per transfer
  always @(negedge hz100) begin
    if (arstN === 1'b1) begin
      // busy lights red for the whole transfer
      if (red !== ~right[0])
        reportError($sformatf("red is %b with csx %b", red, right[0]));
      if (right[0] == 1'b0) begin
        lowCycles++;
      end else if (lowCycles != 0) begin
        if (lowCycles != 7)
          reportError($sformatf("csx low for %0d cycles, expected 7", lowCycles));
        lowCycles = 0;
        xferCnt++;
      end
    end
  end

  // a real key in b makes a two key press that yields no code
  task automatic pressKeys(input logic [4:0] a, input logic [4:0] b, input int holdScans);
    logic [4:0] expCode;
    int         waited;
    expCode = (b == KEY_NONE) ? a : KEY_NONE;
    @(negedge hz100);
    keyA = a;
    keyB = b;
    waited = 0;
    while (expCode != KEY_NONE && ss1[4:0] != expCode) begin
      @(negedge hz100);
      waited++;
      if (waited > (DEBOUNCE_SCANS + 2) * SCAN_CYCLES)
        timeoutStop("the pressed key never showed up on ss1");
    end
    // held key keeps its code without a repeat
    for (int i = waited; i < holdScans * SCAN_CYCLES; i++) begin
      @(negedge hz100);
      checkKey(ss1[4:0], expCode);
    end
    keyA = KEY_NONE;
    keyB = KEY_NONE;
    waited = 0;
    while (ss1[4:0] != KEY_NONE) begin
      @(negedge hz100);
      waited++;
      if (waited > 3 * SCAN_CYCLES)
        timeoutStop("ss1 never went back to no key after release");
    end
    for (int i = waited; i < 2 * SCAN_CYCLES; i++)
      @(negedge hz100);
    checkKey(ss1[4:0], KEY_NONE);
  endtask

  task automatic checkLcd(input logic write, input logic [7:0] acc, input int xferBefore);
    if (lcdData.size() != (write ? 2 : 0))
      reportError($sformatf("saw %0d lcd writes, expected %0d",
                            lcdData.size(), write ? 2 : 0));
    if (write) begin
      checkByte(lcdData[0], lcdDcx[0], CMD_MEM_WRITE, 1'b0);
      checkByte(lcdData[1], lcdDcx[1], acc, 1'b1);
    end
    if (xferCnt - xferBefore != int'(write))
      reportError($sformatf("saw %0d csx transfers", xferCnt - xferBefore));
  endtask

  task automatic applyKey(input logic [4:0] code, input int holdScans);
    calcStateT exp;
    int        xferBefore;
    exp = nextState(model, code);
    xferBefore = xferCnt;
    lcdDcx.delete();
    lcdData.delete();
    pressKeys(code, KEY_NONE, holdScans);
    checkReg(ss7, exp.acc, "acc on ss7");
    checkReg(ss5, exp.entry, "entry on ss5");
    checkFlags(green, blue, exp.carry, exp.bad);
    checkLcd(exp.write, exp.acc, xferBefore);
    model = exp;
  endtask

  initial begin
    int         len;
    int         xferMark;
    logic [4:0] ops[3];
    void'($urandom(65));
    ops = '{5'd10, 5'd11, 5'd13};
    arstN = 1'b0;
    keyA = KEY_NONE;
    keyB = KEY_NONE;
    model = '0;
    repeat (2) @(negedge hz100);
    // idle outputs in reset with wrx and csx high and dcx low
    checkReg(right, 8'h05, "lcd strobes");
    checkReg({7'd0, red}, 8'd0, "busy led");
    checkReg(ss7, 8'd0, "acc on ss7");
    checkReg(ss5, 8'd0, "entry on ss5");
    checkReg(ss0, 8'd0, "columns before the first scan");
    checkReg(ss2 | ss3 | ss4 | ss6, 8'd0, "unused segment lines");
    repeat (2) @(negedge hz100);
    arstN = 1'b1;
    // 255 + 9 wraps with carry
    applyKey(5'd2, 4);
    applyKey(5'd5, 4);
    applyKey(5'd5, 4);
    applyKey(5'd10, 4);
    applyKey(5'd9, 4);
    applyKey(5'd10, 4);
    // borrow from a small acc
    applyKey(5'd12, 4);
    applyKey(5'd5, 4);
    applyKey(5'd11, 4);
    applyKey(5'd3, 4);
    applyKey(5'd13, 4);
    // long hold gives a single digit
    applyKey(5'd7, 10);
    // two keys in one column, then two in different rows and columns
    xferMark = xferCnt;
    lcdDcx.delete();
    lcdData.delete();
    pressKeys(5'd0, 5'd4, 4);
    pressKeys(5'd1, 5'd6, 4);
    checkReg(ss5, model.entry, "entry after two keys");
    checkLcd(1'b0, 8'd0, xferMark);
    // unused codes only flag blue
    applyKey(5'd14, 4);
    applyKey(5'd15, 4);
    applyKey(5'd12, 4);
    // random digit strings that may pass 255
    for (int s = 0; s < 6; s++) begin
      len = 1 + $urandom % 4;
      for (int d = 0; d < len; d++)
        applyKey(5'($urandom % 10), 4);
      applyKey(ops[$urandom % 3], 4);
    end
    $display("test passed");
    $finish;
  end

endmodule

//--- top.f
design/t04Pkg.sv
design/keypadScanner.sv
design/calcCore.sv
design/screenWriter.sv
design/top.sv
tb/tbTop.sv

//--- run.sh
#!/bin/sh
# build the keypad calculator testbench with Verilator and run it
# exit status is nonzero when the simulation ends in $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbTop -f top.f -o simTop \
  && ./obj_dir/simTop \
  || { echo "simulation did not complete cleanly"; exit 1; }
